// ==== hdl/core_pkg.sv ====
/* TL-UL channel structs and opcodes, core opcodes, crash dump struct
   and sizing constants for the core wrapper */
`default_nettype none

package core_pkg;

  // source ID width on both TL-UL ports
  localparam int unsigned SourceW = 3;

  // outstanding request limits per host adapter
  localparam int unsigned InstrMaxReqs = 2;
  localparam int unsigned DataMaxReqs  = 2;

  // pipeline FIFO depth, 0 gives a direct path
  localparam int unsigned FifoDepth = 2;

  // core register file size
  localparam int unsigned NumRegs = 4;

  // A channel opcodes, TL-UL encoding
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  // D channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  typedef struct packed {
    logic               a_valid;
    tl_a_op_e           a_opcode;
    logic [31:0]        a_address;
    logic [3:0]         a_mask;
    logic [31:0]        a_data;
    logic [SourceW-1:0] a_source;
    logic               d_ready;
  } tl_h2d_t;

  typedef struct packed {
    logic               d_valid;
    tl_d_op_e           d_opcode;
    logic [31:0]        d_data;
    logic [SourceW-1:0] d_source;
    logic               d_error;
    logic               a_ready;
  } tl_d2h_t;

  // instruction bits [31:28]
  typedef enum logic [3:0] {
    OpLoadImm = 4'h1,
    OpAdd     = 4'h2,
    OpLoad    = 4'h3,
    OpStore   = 4'h4,
    OpHalt    = 4'hf
  } core_op_e;

  typedef struct packed {
    logic [31:0] current_pc;
    logic [31:0] last_data_addr;
  } crash_dump_t;

endpackage

`default_nettype wire

// ==== hdl/core_bus_if.sv ====
/* req/gnt/rvalid memory bus between the core and a host adapter */
`default_nettype none

interface core_bus_if ();

  // request side, held stable until granted
  logic        req;
  logic [31:0] addr;
  logic        we;
  logic [3:0]  be;
  logic [31:0] wdata;

  // grant and in-order response
  logic        gnt;
  logic        rvalid;
  logic [31:0] rdata;
  logic        err;

  modport core (output req, addr, we, be, wdata, input gnt, rvalid, rdata, err);

  modport adapter (input req, addr, we, be, wdata, output gnt, rvalid, rdata, err);

endinterface

`default_nettype wire

// ==== hdl/tl_if.sv ====
/* TL-UL link carrying the host-to-device and device-to-host channel
   structs, with host and device views */
`default_nettype none

interface tl_if import core_pkg::*; ();

  // A channel plus d_ready
  tl_h2d_t h2d;

  // D channel plus a_ready
  tl_d2h_t d2h;

  // host issues A beats and accepts D beats
  modport host (output h2d, input d2h);

  // device accepts A beats and returns D beats
  modport device (input h2d, output d2h);

endinterface

`default_nettype wire

// ==== hdl/mini_core.sv ====
/* Sequential fetch/execute core with four registers, an instruction
   bus and a data bus, halt and crash dump on an error response */
`default_nettype none

module mini_core import core_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        reset_i,
  input  wire logic        fetch_enable_i,
  input  wire logic [31:0] boot_addr_i,
  core_bus_if.core         instr_bus,
  core_bus_if.core         data_bus,
  output crash_dump_t      crash_dump_o,
  output logic             core_sleep_o
);

  typedef enum logic [2:0] {
    StFetch,
    StWaitFetch,
    StExecute,
    StData,
    StWaitData,
    StHalted
  } state_e;

  state_e      state_q;
  logic [31:0] pc_q;
  logic [31:0] instr_q;
  logic [31:0] data_addr_q;
  logic        fetch_hold_q;
  logic [31:0] rf_q [NumRegs];

  core_op_e    op;
  logic [1:0]  rd;
  logic [1:0]  rs1;
  logic [1:0]  rs2;
  logic [31:0] imm;
  logic [31:0] mem_addr;
  logic        instr_req;

  // instruction fields
  assign op       = core_op_e'(instr_q[31:28]);
  assign rd       = instr_q[27:26];
  assign rs1      = instr_q[25:24];
  assign rs2      = instr_q[23:22];
  assign imm      = {16'h0000, instr_q[15:0]};
  assign mem_addr = rf_q[rs1] + imm;

  // once raised, a fetch request stays up until granted
  assign instr_req = (state_q == StFetch) & (fetch_enable_i | fetch_hold_q);

  assign instr_bus.req   = instr_req;
  assign instr_bus.addr  = pc_q;
  assign instr_bus.we    = 1'b0;
  assign instr_bus.be    = 4'hf;
  assign instr_bus.wdata = '0;

  // full-word accesses only, store data from rs2
  assign data_bus.req   = (state_q == StData);
  assign data_bus.addr  = data_addr_q;
  assign data_bus.we    = (op == OpStore);
  assign data_bus.be    = 4'hf;
  assign data_bus.wdata = rf_q[rs2];

  // pc and data address freeze once halted
  assign crash_dump_o = '{current_pc: pc_q, last_data_addr: data_addr_q};
  assign core_sleep_o = (state_q == StHalted);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q      <= StFetch;
      pc_q         <= boot_addr_i;
      data_addr_q  <= '0;
      fetch_hold_q <= 1'b0;
    end else begin
      fetch_hold_q <= instr_req & ~instr_bus.gnt;
      case (state_q)
        StFetch: begin
          if (instr_req && instr_bus.gnt) begin
            state_q <= StWaitFetch;
          end
        end
        StWaitFetch: begin
          if (instr_bus.rvalid) begin
            state_q <= instr_bus.err ? StHalted : StExecute;
          end
        end
        StExecute: begin
          case (op)
            OpLoadImm, OpAdd: begin
              pc_q    <= pc_q + 32'd4;
              state_q <= StFetch;
            end
            OpLoad, OpStore: begin
              data_addr_q <= mem_addr;
              state_q     <= StData;
            end
            // halt and unknown opcodes stop the core
            default: state_q <= StHalted;
          endcase
        end
        StData: begin
          if (data_bus.gnt) begin
            state_q <= StWaitData;
          end
        end
        StWaitData: begin
          if (data_bus.rvalid) begin
            if (data_bus.err) begin
              state_q <= StHalted;
            end else begin
              pc_q    <= pc_q + 32'd4;
              state_q <= StFetch;
            end
          end
        end
        default: state_q <= StHalted;
      endcase
    end
  end

  // instruction latch and register file writes
  always_ff @(posedge clk_i) begin
    if (state_q == StWaitFetch && instr_bus.rvalid) begin
      instr_q <= instr_bus.rdata;
    end
    if (state_q == StExecute && op == OpLoadImm) begin
      rf_q[rd] <= imm;
    end else if (state_q == StExecute && op == OpAdd) begin
      rf_q[rd] <= rf_q[rs1] + rf_q[rs2];
    end else if (state_q == StWaitData && data_bus.rvalid && !data_bus.err && op == OpLoad) begin
      rf_q[rd] <= data_bus.rdata;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/bus_host_adapter.sv ====
/* Host adapter from a req/gnt/rvalid core bus to TL-UL A and D
   channels, with a limit on outstanding requests */
`default_nettype none

module bus_host_adapter import core_pkg::*; #(
  parameter int unsigned MaxReqs = 2
) (
  input  wire logic   clk_i,
  input  wire logic   reset_i,
  core_bus_if.adapter core_bus,
  tl_if.host          tl
);

  localparam int unsigned CntW = $clog2(MaxReqs + 1);
  localparam logic [CntW-1:0] MaxCnt = CntW'(MaxReqs);

  logic [CntW-1:0]    outstanding_q;
  logic [SourceW-1:0] source_q;
  logic               below_limit;
  logic               a_xfer;
  logic               d_xfer;
  tl_a_op_e           a_opcode;
  tl_h2d_t            h2d;

  assign below_limit = (outstanding_q < MaxCnt);

  // grant only when the A beat goes out this cycle
  assign core_bus.gnt = core_bus.req & tl.d2h.a_ready & below_limit;

  // partial mask on a write gives PutPartialData
  always_comb begin
    if (!core_bus.we) begin
      a_opcode = Get;
    end else if (core_bus.be == 4'hf) begin
      a_opcode = PutFullData;
    end else begin
      a_opcode = PutPartialData;
    end
  end

  always_comb begin
    h2d.a_valid   = core_bus.req & below_limit;
    h2d.a_opcode  = a_opcode;
    h2d.a_address = core_bus.addr;
    h2d.a_mask    = core_bus.we ? core_bus.be : 4'hf;
    h2d.a_data    = core_bus.wdata;
    h2d.a_source  = source_q;
    // responses are never back-pressured
    h2d.d_ready   = 1'b1;
  end

  assign tl.h2d = h2d;

  assign a_xfer = h2d.a_valid & tl.d2h.a_ready;
  assign d_xfer = tl.d2h.d_valid & h2d.d_ready;

  // D beat goes straight back to the core
  assign core_bus.rvalid = tl.d2h.d_valid;
  assign core_bus.rdata  = tl.d2h.d_data;
  assign core_bus.err    = tl.d2h.d_error;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_q <= '0;
      source_q      <= '0;
    end else begin
      case ({a_xfer, d_xfer})
        2'b10:   outstanding_q <= outstanding_q + 1'b1;
        2'b01:   outstanding_q <= outstanding_q - 1'b1;
        default: outstanding_q <= outstanding_q;
      endcase
      // wrapping source ID
      if (a_xfer) begin
        source_q <= source_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/tl_fifo.sv ====
/* TL-UL pipeline FIFO with one queue for A beats and one for D beats,
   a direct path when Depth is zero */
`default_nettype none

module tl_fifo import core_pkg::*; #(
  parameter int unsigned Depth = 2
) (
  input  wire logic clk_i,
  input  wire logic reset_i,
  tl_if.device      host_side,
  tl_if.host        dev_side
);

  if (Depth == 0) begin : g_pass
    assign dev_side.h2d  = host_side.h2d;
    assign host_side.d2h = dev_side.d2h;
  end else begin : g_queue
    localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam logic [PtrW:0] Full = (PtrW + 1)'(Depth);

    tl_h2d_t       a_mem [Depth];
    tl_d2h_t       d_mem [Depth];
    logic [PtrW-1:0] a_wr_q, a_rd_q, d_wr_q, d_rd_q;
    logic [PtrW:0]   a_cnt_q, d_cnt_q;
    logic          a_push, a_pop, d_push, d_pop;
    tl_h2d_t       h2d_out;
    tl_d2h_t       d2h_out;

    function automatic logic [PtrW-1:0] step(input logic [PtrW-1:0] ptr);
      return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign a_push = host_side.h2d.a_valid & (a_cnt_q != Full);
    assign a_pop  = (a_cnt_q != '0) & dev_side.d2h.a_ready;
    assign d_push = dev_side.d2h.d_valid & (d_cnt_q != Full);
    assign d_pop  = (d_cnt_q != '0) & host_side.h2d.d_ready;

    // head entries out, ready means free space
    always_comb begin
      h2d_out         = a_mem[a_rd_q];
      h2d_out.a_valid = (a_cnt_q != '0);
      h2d_out.d_ready = (d_cnt_q != Full);
      d2h_out         = d_mem[d_rd_q];
      d2h_out.d_valid = (d_cnt_q != '0);
      d2h_out.a_ready = (a_cnt_q != Full);
    end

    assign dev_side.h2d  = h2d_out;
    assign host_side.d2h = d2h_out;

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        a_wr_q  <= '0;
        a_rd_q  <= '0;
        a_cnt_q <= '0;
        d_wr_q  <= '0;
        d_rd_q  <= '0;
        d_cnt_q <= '0;
      end else begin
        if (a_push) a_wr_q <= step(a_wr_q);
        if (a_pop)  a_rd_q <= step(a_rd_q);
        if (d_push) d_wr_q <= step(d_wr_q);
        if (d_pop)  d_rd_q <= step(d_rd_q);
        a_cnt_q <= a_cnt_q + (PtrW + 1)'(a_push) - (PtrW + 1)'(a_pop);
        d_cnt_q <= d_cnt_q + (PtrW + 1)'(d_push) - (PtrW + 1)'(d_pop);
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_push) a_mem[a_wr_q] <= host_side.h2d;
      if (d_push) d_mem[d_wr_q] <= dev_side.d2h;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/core_wrapper.sv ====
/* Core wrapper with the core, an instruction and a data host adapter,
   and a pipeline FIFO in front of each TL-UL port */
`default_nettype none

module core_wrapper import core_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        reset_i,
  input  wire logic        fetch_enable_i,
  input  wire logic [31:0] boot_addr_i,

  // instruction port
  output tl_h2d_t          tl_i_o,
  input  wire tl_d2h_t     tl_i_i,

  // data port
  output tl_h2d_t          tl_d_o,
  input  wire tl_d2h_t     tl_d_i,

  output crash_dump_t      crash_dump_o,
  output logic             core_sleep_o
);

  core_bus_if instr_bus ();
  core_bus_if data_bus ();

  // adapter to FIFO, then FIFO to port
  tl_if tl_i_core ();
  tl_if tl_i_dev ();
  tl_if tl_d_core ();
  tl_if tl_d_dev ();

  mini_core u_core (
    .clk_i,
    .reset_i,
    .fetch_enable_i,
    .boot_addr_i,
    .instr_bus    (instr_bus),
    .data_bus     (data_bus),
    .crash_dump_o,
    .core_sleep_o
  );

  bus_host_adapter #(.MaxReqs(InstrMaxReqs)) u_adapter_i (
    .clk_i,
    .reset_i,
    .core_bus (instr_bus),
    .tl       (tl_i_core)
  );

  tl_fifo #(.Depth(FifoDepth)) u_fifo_i (
    .clk_i,
    .reset_i,
    .host_side (tl_i_core),
    .dev_side  (tl_i_dev)
  );

  bus_host_adapter #(.MaxReqs(DataMaxReqs)) u_adapter_d (
    .clk_i,
    .reset_i,
    .core_bus (data_bus),
    .tl       (tl_d_core)
  );

  tl_fifo #(.Depth(FifoDepth)) u_fifo_d (
    .clk_i,
    .reset_i,
    .host_side (tl_d_core),
    .dev_side  (tl_d_dev)
  );

  assign tl_i_o       = tl_i_dev.h2d;
  assign tl_i_dev.d2h = tl_i_i;
  assign tl_d_o       = tl_d_dev.h2d;
  assign tl_d_dev.d2h = tl_d_i;

endmodule

`default_nettype wire

// ==== dv/tl_mem_model.sv ====
/* TL-UL device memory model with random a_ready stalls, in-order
   responses after random delays and an error at one address */
`default_nettype none

module tl_mem_model import core_pkg::*; (
  input  wire logic        clk_i,
  input  wire logic        reset_i,
  input  wire tl_h2d_t     h2d_i,
  output tl_d2h_t          d2h_o,
  input  wire logic [31:0] err_addr_i,
  output int               a_beats_o,
  output int               d_beats_o,
  output int               max_out_o
);
  timeunit 1ns;
  timeprecision 100ps;

  integer      seed = 32'h88ba;
  logic [31:0] mem [logic [31:0]];
  tl_d2h_t     resp_q [$];
  tl_d2h_t     d2h_q = '0;

  assign d2h_o = d2h_q;

  // unwritten words read back as a fill built from the address
  function automatic logic [31:0] read_word(input logic [31:0] addr);
    return mem.exists(addr) ? mem[addr] : addr ^ 32'hc0de_5a5a;
  endfunction

  // beats are taken at the rising edge
  always @(posedge clk_i) begin
    tl_d2h_t     rsp;
    logic [31:0] word;
    if (reset_i) begin
      resp_q.delete();
      a_beats_o = 0;
      d_beats_o = 0;
      max_out_o = 0;
    end else begin
      if (d2h_q.d_valid && h2d_i.d_ready) begin
        void'(resp_q.pop_front());
        d_beats_o++;
      end
      if (h2d_i.a_valid && d2h_q.a_ready) begin
        rsp = '0;
        rsp.d_source = h2d_i.a_source;
        rsp.d_error  = (h2d_i.a_address == err_addr_i);
        if (h2d_i.a_opcode == Get) begin
          rsp.d_opcode = AccessAckData;
          rsp.d_data   = read_word(h2d_i.a_address);
        end else begin
          rsp.d_opcode = AccessAck;
          word = read_word(h2d_i.a_address);
          for (int b = 0; b < 4; b++) begin
            if (h2d_i.a_mask[b]) begin
              word[8*b +: 8] = h2d_i.a_data[8*b +: 8];
            end
          end
          mem[h2d_i.a_address] = word;
        end
        resp_q.push_back(rsp);
        a_beats_o++;
      end
      if (a_beats_o - d_beats_o > max_out_o) begin
        max_out_o = a_beats_o - d_beats_o;
      end
    end
  end

  // outputs change on the falling edge
  always @(negedge clk_i) begin
    tl_d2h_t nxt;
    nxt = '0;
    if (!reset_i) begin
      // a response once shown stays until taken
      if (resp_q.size() != 0 && (d2h_q.d_valid || $random(seed) % 2 == 0)) begin
        nxt         = resp_q[0];
        nxt.d_valid = 1'b1;
      end
      // about one cycle in four without a_ready
      nxt.a_ready = ($random(seed) % 4) != 0;
    end
    d2h_q = nxt;
  end

endmodule

`default_nettype wire

// ==== dv/tb_core_wrapper.sv ====
/* Testbench for the core wrapper: clock and reset, cases from a data
   file, A beat monitors on both ports, compare tasks and a report */
`default_nettype none

module tb_core_wrapper import core_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic        clk_i;
  logic        reset_i;
  logic        fetch_enable_i;
  logic [31:0] boot_addr_i;
  logic [31:0] err_addr;
  tl_h2d_t     tl_i_o;
  tl_d2h_t     tl_i_i;
  tl_h2d_t     tl_d_o;
  tl_d2h_t     tl_d_i;
  crash_dump_t crash_dump_o;
  logic        core_sleep_o;

  logic [31:0] cases [256];
  tl_h2d_t     exp_data_q [$];
  logic [31:0] cur_boot;
  int          cur_n_instr;
  int          fetch_idx;
  logic        enabled_once;
  int          cycle_count;
  int          cycle_limit;
  int          beat_errs;
  int          crash_errs;
  int          word_errs;
  int          count_errs;
  int          i_a_beats;
  int          i_d_beats;
  int          i_max_out;
  int          d_a_beats;
  int          d_d_beats;
  int          d_max_out;

  core_wrapper core_wrapper_i (
    .clk_i,
    .reset_i,
    .fetch_enable_i,
    .boot_addr_i,
    .tl_i_o,
    .tl_i_i,
    .tl_d_o,
    .tl_d_i,
    .crash_dump_o,
    .core_sleep_o
  );

  tl_mem_model imem (
    .clk_i,
    .reset_i,
    .h2d_i      (tl_i_o),
    .d2h_o      (tl_i_i),
    .err_addr_i (32'hffff_ffff),
    .a_beats_o  (i_a_beats),
    .d_beats_o  (i_d_beats),
    .max_out_o  (i_max_out)
  );

  tl_mem_model dmem (
    .clk_i,
    .reset_i,
    .h2d_i      (tl_d_o),
    .d2h_o      (tl_d_i),
    .err_addr_i (err_addr),
    .a_beats_o  (d_a_beats),
    .d_beats_o  (d_d_beats),
    .max_out_o  (d_max_out)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  task automatic check_a_beat(input string what, input tl_h2d_t got, input tl_h2d_t want);
    // write data only counts on puts
    if (got.a_opcode !== want.a_opcode || got.a_address !== want.a_address ||
        got.a_mask !== want.a_mask || got.a_source !== want.a_source ||
        (want.a_opcode != Get && got.a_data !== want.a_data)) begin
      beat_errs++;
      $display("[ERROR] %0t: %s A beat op %0h addr %h mask %h data %h src %0d", $time,
               what, got.a_opcode, got.a_address, got.a_mask, got.a_data, got.a_source);
      $display("[ERROR] %0t: expected op %0h addr %h mask %h data %h src %0d", $time,
               want.a_opcode, want.a_address, want.a_mask, want.a_data, want.a_source);
    end
  endtask

  task automatic check_crash(input crash_dump_t got, input crash_dump_t want);
    if (got !== want) begin
      crash_errs++;
      $display("[ERROR] %0t: crash dump pc %h addr %h, expected pc %h addr %h", $time,
               got.current_pc, got.last_data_addr, want.current_pc, want.last_data_addr);
    end
  endtask

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      word_errs++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_count(input string what, input int got, input int want);
    if (got != want) begin
      count_errs++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  // fetches are Gets from rising word addresses
  always @(posedge clk_i) begin
    tl_h2d_t want;
    if (!reset_i && tl_i_o.a_valid && tl_i_i.a_ready) begin
      if (!enabled_once || fetch_idx >= cur_n_instr) begin
        count_errs++;
        $display("[ERROR] %0t: unexpected fetch from %h", $time, tl_i_o.a_address);
      end else begin
        want           = '0;
        want.a_opcode  = Get;
        want.a_address = cur_boot + 32'(4 * fetch_idx);
        want.a_mask    = 4'hf;
        want.a_source  = SourceW'(fetch_idx);
        check_a_beat("instr", tl_i_o, want);
      end
      fetch_idx++;
    end
  end

  always @(posedge clk_i) begin
    tl_h2d_t want;
    if (!reset_i && tl_d_o.a_valid && tl_d_i.a_ready) begin
      if (exp_data_q.size() == 0) begin
        count_errs++;
        $display("[ERROR] %0t: unexpected data beat at %h", $time, tl_d_o.a_address);
      end else begin
        want = exp_data_q.pop_front();
        check_a_beat("data", tl_d_o, want);
      end
    end
  end

  // header, program words, data beats, then crash dump
  task automatic run_case(input int base, output int next);
    logic [31:0] boot;
    int          n_instr;
    int          n_data;
    int          p;
    tl_h2d_t     beat;
    crash_dump_t want_crash;
    logic [31:0] st_addr [$];
    logic [31:0] st_data [$];
    @(negedge clk_i);
    boot           = cases[base];
    n_instr        = int'(cases[base+1]);
    n_data         = int'(cases[base+3]);
    reset_i        = 1'b1;
    fetch_enable_i = 1'b0;
    boot_addr_i    = boot;
    err_addr       = cases[base+2];
    enabled_once   = 1'b0;
    fetch_idx      = 0;
    cur_boot       = boot;
    cur_n_instr    = n_instr;
    p = base + 4;
    for (int i = 0; i < n_instr; i++) begin
      imem.mem[boot + 32'(4 * i)] = cases[p];
      p++;
    end
    exp_data_q.delete();
    for (int i = 0; i < n_data; i++) begin
      beat           = '0;
      beat.a_opcode  = tl_a_op_e'(cases[p][2:0]);
      beat.a_address = cases[p+1];
      beat.a_mask    = 4'hf;
      beat.a_data    = cases[p+2];
      beat.a_source  = SourceW'(i);
      exp_data_q.push_back(beat);
      if (beat.a_opcode == PutFullData) begin
        st_addr.push_back(cases[p+1]);
        st_data.push_back(cases[p+2]);
      end
      p += 3;
    end
    want_crash.current_pc     = cases[p];
    want_crash.last_data_addr = cases[p+1];
    next = p + 2;
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;
    check_count("instr a_valid after reset", int'(tl_i_o.a_valid), 0);
    check_count("data a_valid after reset", int'(tl_d_o.a_valid), 0);
    check_count("core_sleep_o after reset", int'(core_sleep_o), 0);
    // a few idle cycles with fetch disabled
    repeat (3) @(negedge clk_i);
    enabled_once   = 1'b1;
    fetch_enable_i = 1'b1;
    while (!core_sleep_o) begin
      @(negedge clk_i);
    end
    // nothing may follow the stop
    repeat (10) @(negedge clk_i);
    check_crash(crash_dump_o, want_crash);
    check_count("instr A beats", i_a_beats, n_instr);
    check_count("instr D beats", i_d_beats, n_instr);
    check_count("data A beats", d_a_beats, n_data);
    check_count("data D beats", d_d_beats, n_data);
    if (i_max_out > int'(InstrMaxReqs) || d_max_out > int'(DataMaxReqs)) begin
      count_errs++;
      $display("[ERROR] %0t: outstanding requests reached %0d on instr, %0d on data",
               $time, i_max_out, d_max_out);
    end
    for (int i = 0; i < st_addr.size(); i++) begin
      check_word("stored word", dmem.mem[st_addr[i]], st_data[i]);
    end
  endtask

  initial begin
    int p;
    int next;
    int total;
    reset_i        = 1'b1;
    fetch_enable_i = 1'b0;
    boot_addr_i    = '0;
    err_addr       = '1;
    enabled_once   = 1'b0;
    cur_boot       = '0;
    cur_n_instr    = 0;
    fetch_idx      = 0;
    cycle_limit    = 0;
    beat_errs      = 0;
    crash_errs     = 0;
    word_errs      = 0;
    count_errs     = 0;
    $readmemh("dv/wrapper_cases.txt", cases);
    // cycle budget from the summed program length
    p     = 0;
    total = 0;
    while (cases[p+1] != 0) begin
      total += int'(cases[p+1]);
      p += 6 + int'(cases[p+1]) + 3 * int'(cases[p+3]);
    end
    cycle_limit = total * 40;
    if (total == 0) begin
      count_errs++;
      $display("no test cases could be read from dv/wrapper_cases.txt");
    end
    p = 0;
    while (cases[p+1] != 0) begin
      run_case(p, next);
      p = next;
    end
    $display("errors: A beat %0d, crash dump %0d, memory word %0d, count %0d",
             beat_errs, crash_errs, word_errs, count_errs);
    if (beat_errs + crash_errs + word_errs + count_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_limit == 0 || cycle_count < cycle_limit) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout: the core did not finish within %0d cycles", cycle_limit);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/wrapper_cases.txt ====
// case header: boot_addr n_instr err_addr n_data, then the program words,
// then data beats as tl_opcode address data, then crash pc and data address
// li, li, li, add, store sum, load it back, store it again, halt
00000100 00000008 ffffffff 00000003
10000010 14000005 18000007 2d800000
40c00040 34000040 40400044 f0000000
00000000 00000050 0000000c
00000004 00000050 00000000
00000000 00000054 0000000c
0000011c 00000054
// load a fill word, add one, store, then a load that gets an error
00000200 00000006 00000088 00000003
10000080 38000000 14000001 2e400000
40c00004 34000008
00000004 00000080 00000000
00000000 00000084 c0de5adb
00000004 00000088 00000000
00000214 00000088
// sum of two immediates stored at rs1 plus imm, then halt
00001000 00000005 ffffffff 00000001
14001234 180000ff 25800000 42400001 f0000000
00000000 00000100 00001333
00001010 00000100
// end marker
00000000 00000000 00000000 00000000

// ==== files.f ====
hdl/core_pkg.sv
hdl/core_bus_if.sv
hdl/tl_if.sv
hdl/mini_core.sv
hdl/bus_host_adapter.sv
hdl/tl_fifo.sv
hdl/core_wrapper.sv
dv/tl_mem_model.sv
dv/tb_core_wrapper.sv

// ==== Makefile ====
TOP := tb_core_wrapper

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
